//--- hw/alloc_builder.sv
module alloc_builder #(
	parameter int WIDTH = 3
) (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                    [WIDTH-1:0] slot_valid,
	input  dispatch_pkg::xlen_t     [WIDTH-1:0] pc,
	input  dispatch_pkg::pr_idx_t   [WIDTH-1:0] free_pr,
	input  dispatch_pkg::fu_sel_e   [WIDTH-1:0] dec_fu_sel,
	input  dispatch_pkg::op_sel_e   [WIDTH-1:0] dec_op_sel,
	input  dispatch_pkg::opa_sel_e  [WIDTH-1:0] dec_opa_sel,
	input  dispatch_pkg::opb_sel_e  [WIDTH-1:0] dec_opb_sel,
	input  dispatch_pkg::arch_reg_t [WIDTH-1:0] dec_dest_ar,
	input  dispatch_pkg::arch_reg_t [WIDTH-1:0] dec_src1_ar,
	input  dispatch_pkg::arch_reg_t [WIDTH-1:0] dec_src2_ar,
	input  logic                    [WIDTH-1:0] dec_is_store,
	input  logic                    [WIDTH-1:0] dec_halt,
	input  logic                    [WIDTH-1:0] dec_illegal,
	output logic                    [WIDTH-1:0] disp_valid,
	output dispatch_pkg::fu_sel_e   [WIDTH-1:0] fu_sel,
	output dispatch_pkg::op_sel_e   [WIDTH-1:0] op_sel,
	output dispatch_pkg::opa_sel_e  [WIDTH-1:0] opa_sel,
	output dispatch_pkg::opb_sel_e  [WIDTH-1:0] opb_sel,
	output dispatch_pkg::pr_idx_t   [WIDTH-1:0] dest_pr,
	output dispatch_pkg::arch_reg_t [WIDTH-1:0] map_ar,  // to map table
	output dispatch_pkg::arch_reg_t [WIDTH-1:0] src1_ar, // map table lookups
	output dispatch_pkg::arch_reg_t [WIDTH-1:0] src2_ar,
	output logic                    [WIDTH-1:0] new_pr_en, // free list pop + mt write
	output logic                    [WIDTH-1:0] sq_alloc,
	output logic                    [WIDTH-1:0] bp_en,
	output dispatch_pkg::xlen_t     [WIDTH-1:0] bp_pc,
	output logic                    [WIDTH-1:0] halt,
	output logic                    [WIDTH-1:0] illegal
);
	import dispatch_pkg::*;

	logic      [WIDTH-1:0] new_pr_en_d;
	logic      [WIDTH-1:0] sq_alloc_d;
	logic      [WIDTH-1:0] bp_en_d;
	pr_idx_t   [WIDTH-1:0] dest_pr_d;
	arch_reg_t [WIDTH-1:0] map_ar_d;
	xlen_t     [WIDTH-1:0] bp_pc_d;

	always_comb begin
		for (int i = 0; i < WIDTH; i++) begin
			// writes to x0 never take a physical register
			new_pr_en_d[i] = slot_valid[i] && (dec_dest_ar[i] != ZERO_REG);
			dest_pr_d[i]   = new_pr_en_d[i] ? free_pr[i] : '0;
			map_ar_d[i]    = slot_valid[i] ? dec_dest_ar[i] : ZERO_REG;
			sq_alloc_d[i]  = slot_valid[i] & dec_is_store[i];
			bp_en_d[i]     = slot_valid[i] && (dec_fu_sel[i] == FU_BRANCH);
			bp_pc_d[i]     = bp_en_d[i] ? pc[i] : '0;
		end
	end

	// control flops
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			disp_valid <= '0;
			new_pr_en  <= '0;
			sq_alloc   <= '0;
			bp_en      <= '0;
			halt       <= '0;
			illegal    <= '0;
		end else begin
			disp_valid <= slot_valid;
			new_pr_en  <= new_pr_en_d;
			sq_alloc   <= sq_alloc_d;
			bp_en      <= bp_en_d;
			halt       <= dec_halt;
			illegal    <= dec_illegal;
		end
	end

	// payload, only meaningful alongside the control bits above
	always_ff @(posedge clk) begin
		fu_sel  <= dec_fu_sel;
		op_sel  <= dec_op_sel;
		opa_sel <= dec_opa_sel;
		opb_sel <= dec_opb_sel;
		dest_pr <= dest_pr_d;
		map_ar  <= map_ar_d;
		src1_ar <= dec_src1_ar;
		src2_ar <= dec_src2_ar;
		bp_pc   <= bp_pc_d;
	end

	sq_alloc_is_dispatched: assert property (@(posedge clk) disable iff (!arst_n)
		(sq_alloc & ~disp_valid) == '0)
		else $error("alloc_builder: sq_alloc %b without disp_valid %b", sq_alloc, disp_valid);

endmodule

//--- hw/dispatch_pkg.sv
package dispatch_pkg;

	localparam int XLEN    = 32;
	localparam int PR_BITS = 6; // 64 physical registers

	typedef logic [XLEN-1:0]    xlen_t;
	typedef logic [31:0]        inst_t;
	typedef logic [4:0]         arch_reg_t;
	typedef logic [PR_BITS-1:0] pr_idx_t;

	localparam arch_reg_t ZERO_REG = 5'd0; // x0, never renamed

	typedef enum logic [1:0] {
		FU_ALU    = 2'd0,
		FU_LS     = 2'd1,
		FU_MULT   = 2'd2,
		FU_BRANCH = 2'd3
	} fu_sel_e;

	// one code space shared by all units, fu_sel tells them apart
	typedef enum logic [4:0] {
		OP_ADD    = 5'd0,
		OP_SUB    = 5'd1,
		OP_SLT    = 5'd2,
		OP_SLTU   = 5'd3,
		OP_AND    = 5'd4,
		OP_OR     = 5'd5,
		OP_XOR    = 5'd6,
		OP_SLL    = 5'd7,
		OP_SRL    = 5'd8,
		OP_SRA    = 5'd9,
		OP_UNCOND = 5'd10, // jal / jalr
		OP_BEQ    = 5'd11,
		OP_BNE    = 5'd12,
		OP_BLT    = 5'd13,
		OP_BGE    = 5'd14,
		OP_BLTU   = 5'd15,
		OP_BGEU   = 5'd16,
		OP_LB     = 5'd17,
		OP_LH     = 5'd18,
		OP_LW     = 5'd19,
		OP_LBU    = 5'd20,
		OP_LHU    = 5'd21,
		OP_SB     = 5'd22, // stores go down the alu for address calc
		OP_SH     = 5'd23,
		OP_SW     = 5'd24,
		OP_MUL    = 5'd25,
		OP_MULH   = 5'd26,
		OP_MULHSU = 5'd27,
		OP_MULHU  = 5'd28
	} op_sel_e;

	typedef enum logic [1:0] {
		OPA_RS1  = 2'd0,
		OPA_PC   = 2'd1,
		OPA_ZERO = 2'd2
	} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_RS2   = 3'd0,
		OPB_I_IMM = 3'd1,
		OPB_S_IMM = 3'd2,
		OPB_B_IMM = 3'd3,
		OPB_U_IMM = 3'd4,
		OPB_J_IMM = 3'd5
	} opb_sel_e;

endpackage

//--- hw/dispatch_stage.sv
module dispatch_stage #(
	parameter int WIDTH = 3 // number of slots with WIDTH-1 the oldest
) (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                    [WIDTH-1:0] inst_valid,
	input  dispatch_pkg::inst_t     [WIDTH-1:0] inst,
	input  dispatch_pkg::xlen_t     [WIDTH-1:0] pc,
	input  logic                    [WIDTH-1:0] predict_taken,
	input  logic                    [WIDTH-1:0] rs_stall,
	input  logic                    [WIDTH-1:0] rob_stall,
	input  logic                    [WIDTH-1:0] sq_stall,
	input  logic                    [WIDTH-1:0] free_reg_valid,
	input  dispatch_pkg::pr_idx_t   [WIDTH-1:0] free_pr,
	output logic                    [WIDTH-1:0] d_stall, // back to fetch in the same cycle
	output logic                    [WIDTH-1:0] disp_valid,
	output dispatch_pkg::fu_sel_e   [WIDTH-1:0] fu_sel,
	output dispatch_pkg::op_sel_e   [WIDTH-1:0] op_sel,
	output dispatch_pkg::opa_sel_e  [WIDTH-1:0] opa_sel,
	output dispatch_pkg::opb_sel_e  [WIDTH-1:0] opb_sel,
	output dispatch_pkg::pr_idx_t   [WIDTH-1:0] dest_pr,
	output dispatch_pkg::arch_reg_t [WIDTH-1:0] map_ar,
	output dispatch_pkg::arch_reg_t [WIDTH-1:0] src1_ar,
	output dispatch_pkg::arch_reg_t [WIDTH-1:0] src2_ar,
	output logic                    [WIDTH-1:0] new_pr_en,
	output logic                    [WIDTH-1:0] sq_alloc,
	output logic                    [WIDTH-1:0] bp_en,
	output dispatch_pkg::xlen_t     [WIDTH-1:0] bp_pc,
	output logic                    [WIDTH-1:0] halt,
	output logic                    [WIDTH-1:0] illegal
);
	import dispatch_pkg::*;

	logic      [WIDTH-1:0] slot_valid; // survives stall and cancel
	fu_sel_e   [WIDTH-1:0] dec_fu_sel;
	op_sel_e   [WIDTH-1:0] dec_op_sel;
	opa_sel_e  [WIDTH-1:0] dec_opa_sel;
	opb_sel_e  [WIDTH-1:0] dec_opb_sel;
	arch_reg_t [WIDTH-1:0] dec_dest_ar;
	arch_reg_t [WIDTH-1:0] dec_src1_ar;
	arch_reg_t [WIDTH-1:0] dec_src2_ar;
	logic      [WIDTH-1:0] dec_is_store;
	logic      [WIDTH-1:0] dec_halt;
	logic      [WIDTH-1:0] dec_illegal;

	slot_gate #(.WIDTH(WIDTH)) slot_gate_inst (.*);

	for (genvar i = 0; i < WIDTH; i++) begin : g_dec
		rv32_decoder rv32_decoder_inst (
			.slot_valid (slot_valid[i]),
			.inst       (inst[i]),
			.fu_sel     (dec_fu_sel[i]),
			.op_sel     (dec_op_sel[i]),
			.opa_sel    (dec_opa_sel[i]),
			.opb_sel    (dec_opb_sel[i]),
			.dest_ar    (dec_dest_ar[i]),
			.src1_ar    (dec_src1_ar[i]),
			.src2_ar    (dec_src2_ar[i]),
			.is_store   (dec_is_store[i]),
			.halt       (dec_halt[i]),
			.illegal    (dec_illegal[i])
		);
	end

	alloc_builder #(.WIDTH(WIDTH)) alloc_builder_inst (.*);

endmodule

//--- hw/rv32_decoder.sv
module rv32_decoder (
	input  logic                    slot_valid, // outputs are a noop when low
	input  dispatch_pkg::inst_t     inst,
	output dispatch_pkg::fu_sel_e   fu_sel,
	output dispatch_pkg::op_sel_e   op_sel,
	output dispatch_pkg::opa_sel_e  opa_sel,
	output dispatch_pkg::opb_sel_e  opb_sel,
	output dispatch_pkg::arch_reg_t dest_ar,
	output dispatch_pkg::arch_reg_t src1_ar,
	output dispatch_pkg::arch_reg_t src2_ar,
	output logic                    is_store,
	output logic                    halt,
	output logic                    illegal
);
	import dispatch_pkg::*;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam inst_t WFI_INST = 32'h1050_0073; // only system op kept

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	arch_reg_t  rd;
	arch_reg_t  rs1;
	arch_reg_t  rs2;

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];

	always_comb begin
		// noop: add x0, x0, x0
		fu_sel   = FU_ALU;
		op_sel   = OP_ADD;
		opa_sel  = OPA_RS1;
		opb_sel  = OPB_RS2;
		dest_ar  = ZERO_REG;
		src1_ar  = ZERO_REG;
		src2_ar  = ZERO_REG;
		is_store = 1'b0;
		halt     = 1'b0;
		illegal  = 1'b0;
		if (slot_valid) begin
			case (opcode)
				OPC_LUI: begin
					opa_sel = OPA_ZERO;
					opb_sel = OPB_U_IMM;
					dest_ar = rd;
				end
				OPC_AUIPC: begin
					opa_sel = OPA_PC;
					opb_sel = OPB_U_IMM;
					dest_ar = rd;
				end
				OPC_JAL: begin
					fu_sel  = FU_BRANCH;
					op_sel  = OP_UNCOND;
					opa_sel = OPA_PC;
					opb_sel = OPB_J_IMM;
					dest_ar = rd;
				end
				OPC_JALR: begin
					fu_sel  = FU_BRANCH;
					op_sel  = OP_UNCOND;
					opb_sel = OPB_I_IMM;
					dest_ar = rd;
					src1_ar = rs1;
					illegal = (funct3 != 3'b000);
				end
				OPC_BRANCH: begin
					fu_sel  = FU_BRANCH;
					opa_sel = OPA_PC;
					opb_sel = OPB_B_IMM;
					src1_ar = rs1; // no rd, branches only compare
					src2_ar = rs2;
					case (funct3)
						3'b000:  op_sel = OP_BEQ;
						3'b001:  op_sel = OP_BNE;
						3'b100:  op_sel = OP_BLT;
						3'b101:  op_sel = OP_BGE;
						3'b110:  op_sel = OP_BLTU;
						3'b111:  op_sel = OP_BGEU;
						default: illegal = 1'b1;
					endcase
				end
				OPC_LOAD: begin
					fu_sel  = FU_LS;
					opb_sel = OPB_I_IMM;
					dest_ar = rd;
					src1_ar = rs1;
					case (funct3)
						3'b000:  op_sel = OP_LB;
						3'b001:  op_sel = OP_LH;
						3'b010:  op_sel = OP_LW;
						3'b100:  op_sel = OP_LBU;
						3'b101:  op_sel = OP_LHU;
						default: illegal = 1'b1;
					endcase
				end
				OPC_STORE: begin
					opb_sel  = OPB_S_IMM;
					src1_ar  = rs1; // base
					src2_ar  = rs2; // data
					is_store = 1'b1;
					case (funct3)
						3'b000:  op_sel = OP_SB;
						3'b001:  op_sel = OP_SH;
						3'b010:  op_sel = OP_SW;
						default: illegal = 1'b1;
					endcase
				end
				OPC_OP_IMM: begin
					opb_sel = OPB_I_IMM;
					dest_ar = rd;
					src1_ar = rs1;
					case (funct3)
						3'b000: op_sel = OP_ADD;
						3'b010: op_sel = OP_SLT;
						3'b011: op_sel = OP_SLTU;
						3'b100: op_sel = OP_XOR;
						3'b110: op_sel = OP_OR;
						3'b111: op_sel = OP_AND;
						3'b001: begin
							op_sel  = OP_SLL;
							illegal = (funct7 != 7'b0000000);
						end
						default: begin // srli / srai, bit 30 picks arithmetic
							op_sel  = funct7[5] ? OP_SRA : OP_SRL;
							illegal = ((funct7 & 7'b1011111) != 7'b0000000);
						end
					endcase
				end
				OPC_OP: begin
					dest_ar = rd;
					src1_ar = rs1;
					src2_ar = rs2;
					case (funct7)
						7'b0000000: begin
							case (funct3)
								3'b000: op_sel = OP_ADD;
								3'b001: op_sel = OP_SLL;
								3'b010: op_sel = OP_SLT;
								3'b011: op_sel = OP_SLTU;
								3'b100: op_sel = OP_XOR;
								3'b101: op_sel = OP_SRL;
								3'b110: op_sel = OP_OR;
								default: op_sel = OP_AND;
							endcase
						end
						7'b0100000: begin
							case (funct3)
								3'b000:  op_sel = OP_SUB;
								3'b101:  op_sel = OP_SRA;
								default: illegal = 1'b1;
							endcase
						end
						7'b0000001: begin
							fu_sel = FU_MULT;
							case (funct3)
								3'b000:  op_sel = OP_MUL;
								3'b001:  op_sel = OP_MULH;
								3'b010:  op_sel = OP_MULHSU;
								3'b011:  op_sel = OP_MULHU;
								default: illegal = 1'b1; // no divider in this core
							endcase
						end
						default: illegal = 1'b1;
					endcase
				end
				OPC_SYSTEM: begin
					if (inst == WFI_INST)
						halt = 1'b1;
					else
						illegal = 1'b1;
				end
				default: illegal = 1'b1;
			endcase
			// bad encodings fall back to the noop fields so nothing gets allocated
			if (illegal) begin
				fu_sel   = FU_ALU;
				op_sel   = OP_ADD;
				opa_sel  = OPA_RS1;
				opb_sel  = OPB_RS2;
				dest_ar  = ZERO_REG;
				src1_ar  = ZERO_REG;
				src2_ar  = ZERO_REG;
				is_store = 1'b0;
			end
		end
	end

	always_comb begin
		assert final (!(halt && illegal))
			else $error("rv32_decoder: halt and illegal both set, inst %h", inst);
	end

endmodule

//--- hw/slot_gate.sv
module slot_gate #(
	parameter int WIDTH = 3 // slot WIDTH-1 is the oldest
) (
	input  logic [WIDTH-1:0] inst_valid,
	input  logic [WIDTH-1:0] predict_taken,
	input  logic [WIDTH-1:0] rs_stall,       // rs full
	input  logic [WIDTH-1:0] rob_stall,      // rob full
	input  logic [WIDTH-1:0] sq_stall,       // store queue full
	input  logic [WIDTH-1:0] free_reg_valid, // free list has a pr for this slot
	output logic [WIDTH-1:0] d_stall,
	output logic [WIDTH-1:0] slot_valid
);

	logic [WIDTH-1:0] older_taken; // some older slot is predicted taken

	// structural hazard per slot
	assign d_stall = rs_stall | rob_stall | sq_stall | ~free_reg_valid;

	// scan from the oldest slot down, anything behind a taken
	// prediction is on the wrong path
	always_comb begin
		older_taken[WIDTH-1] = 1'b0;
		for (int i = WIDTH - 2; i >= 0; i--) begin
			older_taken[i] = older_taken[i+1] | predict_taken[i+1];
		end
	end

	// the taken slot itself still goes
	assign slot_valid = inst_valid & ~d_stall & ~older_taken;

	always_comb begin
		assert final ((d_stall & slot_valid) == '0)
			else $error("slot_gate: stalled slot marked valid, d_stall %b slot_valid %b",
				d_stall, slot_valid);
	end

endmodule

//--- sim.f
hw/dispatch_pkg.sv
hw/rv32_decoder.sv
hw/slot_gate.sv
hw/alloc_builder.sv
hw/dispatch_stage.sv
verification/dispatch_checks.sv
verification/dispatch_tb.sv

//--- verification/dispatch_checks.sv
module dispatch_checks #(
	parameter int WIDTH = 3
) (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                    [WIDTH-1:0] inst_valid, predict_taken, rs_stall,
	input  logic                    [WIDTH-1:0] rob_stall, sq_stall, free_reg_valid,
	input  dispatch_pkg::inst_t     [WIDTH-1:0] inst,
	input  dispatch_pkg::xlen_t     [WIDTH-1:0] pc, bp_pc,
	input  dispatch_pkg::pr_idx_t   [WIDTH-1:0] free_pr, dest_pr,
	input  logic                    [WIDTH-1:0] d_stall, disp_valid, new_pr_en,
	input  logic                    [WIDTH-1:0] sq_alloc, bp_en, halt, illegal,
	input  dispatch_pkg::fu_sel_e   [WIDTH-1:0] fu_sel,
	input  dispatch_pkg::op_sel_e   [WIDTH-1:0] op_sel,
	input  dispatch_pkg::opa_sel_e  [WIDTH-1:0] opa_sel,
	input  dispatch_pkg::opb_sel_e  [WIDTH-1:0] opb_sel,
	input  dispatch_pkg::arch_reg_t [WIDTH-1:0] map_ar, src1_ar, src2_ar,
	output int                                  errors
);
	timeunit 1ns;
	timeprecision 100ps;
	import dispatch_pkg::*;

	// op lookup by funct3
	localparam op_sel_e ALU_OP [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};
	localparam op_sel_e BR_OP [8] = '{OP_BEQ, OP_BNE, OP_ADD, OP_ADD, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
	localparam op_sel_e LD_OP [8] = '{OP_LB, OP_LH, OP_LW, OP_ADD, OP_LBU, OP_LHU, OP_ADD, OP_ADD};
	localparam op_sel_e ST_OP [4] = '{OP_SB, OP_SH, OP_SW, OP_ADD};
	localparam op_sel_e MUL_OP [4] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};

	typedef struct packed {
		logic [WIDTH-1:0]       disp_valid;
		logic [WIDTH-1:0][1:0]  fu_sel;
		logic [WIDTH-1:0][4:0]  op_sel;
		logic [WIDTH-1:0][1:0]  opa_sel;
		logic [WIDTH-1:0][2:0]  opb_sel;
		logic [WIDTH-1:0][4:0]  map_ar;
		logic [WIDTH-1:0][4:0]  src1_ar;
		logic [WIDTH-1:0][4:0]  src2_ar;
		logic [WIDTH-1:0]       sq_alloc;
		logic [WIDTH-1:0]       halt;
		logic [WIDTH-1:0]       illegal;
		logic [WIDTH-1:0]       new_pr_en;
		logic [WIDTH-1:0][5:0]  dest_pr;
		logic [WIDTH-1:0]       bp_en;
		logic [WIDTH-1:0][31:0] bp_pc;
	} expect_t;

	expect_t          nxt;
	expect_t          want; // what the outputs must show this cycle
	logic [WIDTH-1:0] stall_ref;

	initial errors = 0;

	// {fu, op, opa, opb, rd, rs1, rs2, store, halt, illegal}
	function automatic logic [29:0] ref_decode(input logic [31:0] in);
		logic [1:0] fu;
		logic [4:0] op;
		logic [1:0] opa;
		logic [2:0] opb;
		logic [2:0] use_regs; // rd, rs1, rs2
		logic [2:0] flags;
		logic [2:0] f3;
		f3 = in[14:12];
		{fu, op, opa, opb} = {FU_ALU, OP_ADD, OPA_RS1, OPB_RS2};
		use_regs = 3'b000;
		flags = 3'b000;
		case (in[6:0])
			7'b0110111: {opa, opb, use_regs} = {OPA_ZERO, OPB_U_IMM, 3'b100}; // lui
			7'b0010111: {opa, opb, use_regs} = {OPA_PC, OPB_U_IMM, 3'b100};   // auipc
			7'b1101111: {fu, op, opa, opb, use_regs} =
				{FU_BRANCH, OP_UNCOND, OPA_PC, OPB_J_IMM, 3'b100};
			7'b1100111: {fu, op, opb, use_regs} = {FU_BRANCH, OP_UNCOND, OPB_I_IMM, 3'b110};
			7'b1100011: {fu, op, opa, opb, use_regs} =
				{FU_BRANCH, BR_OP[f3], OPA_PC, OPB_B_IMM, 3'b011};
			7'b0000011: {fu, op, opb, use_regs} = {FU_LS, LD_OP[f3], OPB_I_IMM, 3'b110};
			7'b0100011: {op, opb, use_regs, flags} = {ST_OP[f3[1:0]], OPB_S_IMM, 3'b011, 3'b100};
			7'b0010011: begin
				op = (f3 == 3'b101 && in[30]) ? OP_SRA : ALU_OP[f3];
				{opb, use_regs} = {OPB_I_IMM, 3'b110};
			end
			7'b0110011: begin
				use_regs = 3'b111;
				if (in[25])
					{fu, op} = {FU_MULT, MUL_OP[f3[1:0]]};
				else if (in[30])
					op = (f3 == 3'b000) ? OP_SUB : OP_SRA;
				else
					op = ALU_OP[f3];
			end
			7'b1110011: flags = (in == 32'h1050_0073) ? 3'b010 : 3'b001; // wfi only
			default: flags = 3'b001;
		endcase
		return {fu, op, opa, opb, use_regs[2] ? in[11:7] : 5'd0,
			use_regs[1] ? in[19:15] : 5'd0, use_regs[0] ? in[24:20] : 5'd0, flags};
	endfunction

	assign stall_ref = rs_stall | rob_stall | sq_stall | ~free_reg_valid;

	always_comb begin
		logic        older;
		logic [29:0] dec;
		nxt = '0;
		older = 1'b0;
		for (int i = WIDTH - 1; i >= 0; i--) begin // oldest first
			nxt.disp_valid[i] = inst_valid[i] & ~stall_ref[i] & ~older;
			dec = nxt.disp_valid[i] ? ref_decode(inst[i]) : '0;
			older = older | predict_taken[i];
			{nxt.fu_sel[i], nxt.op_sel[i], nxt.opa_sel[i], nxt.opb_sel[i], nxt.map_ar[i],
				nxt.src1_ar[i], nxt.src2_ar[i], nxt.sq_alloc[i], nxt.halt[i],
				nxt.illegal[i]} = dec;
			nxt.new_pr_en[i] = nxt.map_ar[i] != 5'd0;
			nxt.dest_pr[i] = nxt.new_pr_en[i] ? free_pr[i] : '0;
			nxt.bp_en[i] = nxt.fu_sel[i] == FU_BRANCH;
			nxt.bp_pc[i] = nxt.bp_en[i] ? pc[i] : '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			want <= '0; // all zero is the no-op payload too
		else
			want <= nxt;
	end

	task automatic report(input string name, input logic [127:0] exp_v, input logic [127:0] got_v);
		errors++;
		$display("[FAIL] time %0t %s expected %0h actual %0h", $time, name, exp_v, got_v);
	endtask

	a_reset: assert property (@(posedge clk) !arst_n |=>
		{disp_valid, new_pr_en, sq_alloc, bp_en, halt, illegal} == '0)
		else report("control outputs in reset", '0,
			$sampled({disp_valid, new_pr_en, sq_alloc, bp_en, halt, illegal}));
	a_d_stall: assert property (@(posedge clk) disable iff (!arst_n) d_stall == stall_ref)
		else report("d_stall", $sampled(stall_ref), $sampled(d_stall));
	a_disp_valid: assert property (@(posedge clk) disable iff (!arst_n) disp_valid == want.disp_valid)
		else report("disp_valid", $sampled(want.disp_valid), $sampled(disp_valid));
	a_fu_sel: assert property (@(posedge clk) disable iff (!arst_n) fu_sel == want.fu_sel)
		else report("fu_sel", $sampled(want.fu_sel), $sampled(fu_sel));
	a_op_sel: assert property (@(posedge clk) disable iff (!arst_n) op_sel == want.op_sel)
		else report("op_sel", $sampled(want.op_sel), $sampled(op_sel));
	a_opa_sel: assert property (@(posedge clk) disable iff (!arst_n) opa_sel == want.opa_sel)
		else report("opa_sel", $sampled(want.opa_sel), $sampled(opa_sel));
	a_opb_sel: assert property (@(posedge clk) disable iff (!arst_n) opb_sel == want.opb_sel)
		else report("opb_sel", $sampled(want.opb_sel), $sampled(opb_sel));
	a_dest_pr: assert property (@(posedge clk) disable iff (!arst_n) dest_pr == want.dest_pr)
		else report("dest_pr", $sampled(want.dest_pr), $sampled(dest_pr));
	a_map_ar: assert property (@(posedge clk) disable iff (!arst_n) map_ar == want.map_ar)
		else report("map_ar", $sampled(want.map_ar), $sampled(map_ar));
	a_src1_ar: assert property (@(posedge clk) disable iff (!arst_n) src1_ar == want.src1_ar)
		else report("src1_ar", $sampled(want.src1_ar), $sampled(src1_ar));
	a_src2_ar: assert property (@(posedge clk) disable iff (!arst_n) src2_ar == want.src2_ar)
		else report("src2_ar", $sampled(want.src2_ar), $sampled(src2_ar));
	a_new_pr_en: assert property (@(posedge clk) disable iff (!arst_n) new_pr_en == want.new_pr_en)
		else report("new_pr_en", $sampled(want.new_pr_en), $sampled(new_pr_en));
	a_sq_alloc: assert property (@(posedge clk) disable iff (!arst_n) sq_alloc == want.sq_alloc)
		else report("sq_alloc", $sampled(want.sq_alloc), $sampled(sq_alloc));
	a_bp_en: assert property (@(posedge clk) disable iff (!arst_n) bp_en == want.bp_en)
		else report("bp_en", $sampled(want.bp_en), $sampled(bp_en));
	a_bp_pc: assert property (@(posedge clk) disable iff (!arst_n) bp_pc == want.bp_pc)
		else report("bp_pc", $sampled(want.bp_pc), $sampled(bp_pc));
	a_halt: assert property (@(posedge clk) disable iff (!arst_n) halt == want.halt)
		else report("halt", $sampled(want.halt), $sampled(halt));
	a_illegal: assert property (@(posedge clk) disable iff (!arst_n) illegal == want.illegal)
		else report("illegal", $sampled(want.illegal), $sampled(illegal));

endmodule

//--- verification/dispatch_tb.sv
module dispatch_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import dispatch_pkg::*;

	localparam int WIDTH   = 3;
	localparam int N_TMPL  = 43;
	localparam int N_STALL = 60;
	localparam int N_PRED  = 60;
	localparam int N_RAND  = 300;
	// reset, five closing flushes of three cycles, then the groups themselves
	localparam int N_VECTORS = 5 + 15 + N_TMPL + N_STALL + N_PRED + N_RAND;

	// register fields left at zero, filled in per slot
	localparam inst_t TEMPLATES [N_TMPL] = '{
		32'h0000_0037, 32'h0000_0017, 32'h0000_006f, 32'h0000_0067, 32'h0000_0063,
		32'h0000_1063, 32'h0000_4063, 32'h0000_5063, 32'h0000_6063, 32'h0000_7063,
		32'h0000_0003, 32'h0000_1003, 32'h0000_2003, 32'h0000_4003, 32'h0000_5003,
		32'h0000_0023, 32'h0000_1023, 32'h0000_2023, 32'h0000_0013, 32'h0000_2013,
		32'h0000_3013, 32'h0000_4013, 32'h0000_6013, 32'h0000_7013, 32'h0000_1013,
		32'h0000_5013, 32'h4000_5013, 32'h0000_0033, 32'h4000_0033, 32'h0000_1033,
		32'h0000_2033, 32'h0000_3033, 32'h0000_4033, 32'h0000_5033, 32'h4000_5033,
		32'h0000_6033, 32'h0000_7033, 32'h0200_0033, 32'h0200_1033, 32'h0200_2033,
		32'h0200_3033, 32'h1050_0073, 32'h0000_007f // wfi, then an undefined opcode
	};

	logic                  clk = 1'b0;
	logic                  arst_n;
	logic      [WIDTH-1:0] inst_valid, predict_taken, rs_stall, rob_stall, sq_stall;
	logic      [WIDTH-1:0] free_reg_valid;
	inst_t     [WIDTH-1:0] inst;
	xlen_t     [WIDTH-1:0] pc, bp_pc;
	pr_idx_t   [WIDTH-1:0] free_pr, dest_pr;
	logic      [WIDTH-1:0] d_stall, disp_valid, new_pr_en, sq_alloc, bp_en, halt, illegal;
	fu_sel_e   [WIDTH-1:0] fu_sel;
	op_sel_e   [WIDTH-1:0] op_sel;
	opa_sel_e  [WIDTH-1:0] opa_sel;
	opb_sel_e  [WIDTH-1:0] opb_sel;
	arch_reg_t [WIDTH-1:0] map_ar, src1_ar, src2_ar;
	int                    errors;
	int                    errors_seen = 0;
	int                    tests_run = 0;
	int                    tests_failed = 0;

	always #5 clk = ~clk;

	dispatch_stage #(.WIDTH(WIDTH)) dispatch_stage_inst (.*);
	dispatch_checks #(.WIDTH(WIDTH)) dispatch_checks_inst (.*);

	task automatic idle_inputs();
		inst_valid     = '0;
		inst           = '0;
		pc             = '0;
		predict_taken  = '0;
		rs_stall       = '0;
		rob_stall      = '0;
		sq_stall       = '0;
		free_reg_valid = '1;
		free_pr        = '0;
	endtask

	function automatic inst_t make_inst(input int k);
		inst_t w;
		w = TEMPLATES[k];
		if (w != 32'h1050_0073) begin // wfi must stay exact
			w[11:7]  = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom); // x0 dest now and then
			w[19:15] = 5'($urandom);
			w[24:20] = 5'($urandom);
		end
		return w;
	endfunction

	// tmpl < 0 picks a random encoding per slot
	task automatic drive_group(input int tmpl, input bit stalls, input bit predict, input bit sparse);
		@(negedge clk);
		for (int s = 0; s < WIDTH; s++) begin
			inst[s]           = make_inst(tmpl < 0 ? int'($urandom % N_TMPL) : tmpl);
			pc[s]             = xlen_t'($urandom) & ~32'h3;
			inst_valid[s]     = sparse ? ($urandom % 4 != 0) : 1'b1;
			predict_taken[s]  = predict ? ($urandom % 3 == 0) : 1'b0;
			rs_stall[s]       = stalls ? ($urandom % 6 == 0) : 1'b0;
			rob_stall[s]      = stalls ? ($urandom % 6 == 0) : 1'b0;
			sq_stall[s]       = stalls ? ($urandom % 6 == 0) : 1'b0;
			free_reg_valid[s] = stalls ? ($urandom % 6 != 0) : 1'b1;
			free_pr[s]        = pr_idx_t'($urandom);
		end
	endtask

	// flush the last group through the checks before counting
	task automatic close_test(input string name);
		@(negedge clk);
		idle_inputs();
		repeat (2) @(negedge clk);
		tests_run++;
		if (errors != errors_seen)
			tests_failed++;
		$display("test %-8s done, %0d errors", name, errors - errors_seen);
		errors_seen = errors;
	endtask

	initial begin
		#((N_VECTORS + 20) * 10);
		$display("watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(60));
		idle_inputs();
		arst_n = 1'b0;
		repeat (3) drive_group(-1, 1'b1, 1'b1, 1'b1); // traffic while in reset
		@(negedge clk);
		idle_inputs();
		@(negedge clk);
		arst_n = 1'b1;
		close_test("reset");
		for (int k = 0; k < N_TMPL; k++)
			drive_group(k, 1'b0, 1'b0, 1'b0);
		close_test("decode");
		repeat (N_STALL) drive_group(-1, 1'b1, 1'b0, 1'b0);
		close_test("stall");
		repeat (N_PRED) drive_group(-1, 1'b0, 1'b1, 1'b0);
		close_test("predict");
		repeat (N_RAND) drive_group(-1, 1'b1, 1'b1, 1'b1);
		close_test("random");
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
